// File: mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;      // data / address word
    typedef logic [4:0]  reg_addr_t;  // register number

    localparam int REG_COUNT = 32;    // gpr count

    // ------------------------------
    // instruction word fields
    localparam int OP_MSB    = 31;
    localparam int OP_LSB    = 26;
    localparam int RS_MSB    = 25;    // also top of the j target field
    localparam int RS_LSB    = 21;
    localparam int RT_MSB    = 20;
    localparam int RT_LSB    = 16;
    localparam int RD_MSB    = 15;
    localparam int RD_LSB    = 11;
    localparam int FUNCT_MSB = 5;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_MSB   = 15;
    localparam int IMM_LSB   = 0;

    // ------------------------------
    // encodings
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE   = 2'b00,  // register file value
        FWD_MEM_WB = 2'b01,  // write-back value
        FWD_EX_MEM = 2'b10   // alu result one stage ahead
    } fwd_sel_e;

endpackage

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [REG_COUNT];
    logic  wr_live;             // a real write this cycle

    assign wr_live = wr_en && (wr_addr != '0);   // r0 never written

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through, decode sees the value write-back is storing now
    assign rs_data = (wr_live && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (wr_live && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

    a_wr_data_known: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown(wr_data));

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import mips_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,       // hold pc and if/id
    input  logic  pc_src,      // redirect from decode
    input  word_t pc_target,
    input  word_t imem_data,   // instruction word from outside
    output word_t imem_addr,   // pc register itself
    output word_t instr_id,
    output word_t pc_next_id
);

    word_t pc_plus4;

    assign pc_plus4 = imem_addr + 32'd4;

    // ------------------------------
    // program counter
    always_ff @(posedge clk) begin
        if (reset) begin
            imem_addr <= RESET_PC;
        end else if (pc_src) begin
            imem_addr <= pc_target;   // taken beq or j
        end else if (!stall) begin
            imem_addr <= pc_plus4;
        end
    end

    // if/id, flush loads an all-zero word (nop)
    always_ff @(posedge clk) begin
        if (reset || pc_src) begin
            instr_id   <= '0;
            pc_next_id <= '0;
        end else if (!stall) begin
            instr_id   <= imem_data;
            pc_next_id <= pc_plus4;
        end
    end

    // redirect only happens once decode operands are settled
    a_no_stall_redirect: assert property (@(posedge clk) disable iff (reset)
        !(stall && pc_src));

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  word_t     instr_id,
    input  word_t     pc_next_id,
    input  logic      stall,
    input  fwd_sel_e  fwd_c,          // beq rs source
    input  fwd_sel_e  fwd_d,          // beq rt source
    input  word_t     ex_mem_result,
    input  logic      wb_en,          // register file write port
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    output logic      pc_src,
    output word_t     pc_target,
    output reg_addr_t rs_id,
    output reg_addr_t rt_id,
    output logic      branch_id,
    output logic      ex_reg_write,   // id/ex from here on
    output logic      ex_mem_read,
    output logic      ex_mem_write,
    output logic      ex_mem_to_reg,
    output logic      ex_reg_dst,
    output logic      ex_alu_src,
    output alu_op_e   ex_alu_op,
    output word_t     ex_rs_data,
    output word_t     ex_rt_data,
    output word_t     ex_imm,
    output reg_addr_t ex_rs,
    output reg_addr_t ex_rt,
    output reg_addr_t ex_rd
);

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rd_id;
    word_t     imm_id;
    word_t     rs_data;
    word_t     rt_data;
    word_t     cmp_a;
    word_t     cmp_b;
    logic      jump_id;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      mem_to_reg;
    logic      reg_dst;
    logic      alu_src;
    alu_op_e   alu_op;

    assign opcode = opcode_e'(instr_id[OP_MSB:OP_LSB]);
    assign funct  = funct_e'(instr_id[FUNCT_MSB:FUNCT_LSB]);
    assign rs_id  = instr_id[RS_MSB:RS_LSB];
    assign rt_id  = instr_id[RT_MSB:RT_LSB];
    assign rd_id  = instr_id[RD_MSB:RD_LSB];
    assign imm_id = {{16{instr_id[IMM_MSB]}}, instr_id[IMM_MSB:IMM_LSB]};  // sign extend

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (rs_id),
        .rt_addr (rt_id),
        .wr_en   (wb_en),
        .wr_addr (wb_addr),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // ------------------------------
    // control decode
    always_comb begin
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        alu_op     = ALU_ADD;
        branch_id  = 1'b0;
        jump_id    = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                reg_dst   = 1'b1;           // dest is rd
                reg_write = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_write = 1'b0;  // unsupported funct, incl. flush word
                endcase
            end
            OP_ADDI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            OP_LW: begin
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                alu_src    = 1'b1;          // base + offset
            end
            OP_SW: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
            end
            OP_BEQ:  branch_id = 1'b1;
            OP_J:    jump_id   = 1'b1;
            default: ;                      // unknown opcode writes nothing
        endcase
    end

    // ------------------------------
    // branch compare and targets
    assign cmp_a = (fwd_c == FWD_EX_MEM) ? ex_mem_result : rs_data;
    assign cmp_b = (fwd_d == FWD_EX_MEM) ? ex_mem_result : rt_data;

    assign pc_src    = !stall && (jump_id || (branch_id && (cmp_a == cmp_b)));
    assign pc_target = jump_id ? {pc_next_id[31:28], instr_id[RS_MSB:0], 2'b00}
                               : pc_next_id + {imm_id[29:0], 2'b00};

    // id/ex control, bubble on stall
    always_ff @(posedge clk) begin
        if (reset || stall) begin
            ex_reg_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_reg_dst    <= 1'b0;
            ex_alu_src    <= 1'b0;
            ex_alu_op     <= ALU_ADD;
            ex_rs         <= '0;
            ex_rt         <= '0;
            ex_rd         <= '0;
        end else begin
            ex_reg_write  <= reg_write;
            ex_mem_read   <= mem_read;
            ex_mem_write  <= mem_write;
            ex_mem_to_reg <= mem_to_reg;
            ex_reg_dst    <= reg_dst;
            ex_alu_src    <= alu_src;
            ex_alu_op     <= alu_op;
            ex_rs         <= rs_id;
            ex_rt         <= rt_id;
            ex_rd         <= rd_id;
        end
    end

    // id/ex payload
    always_ff @(posedge clk) begin
        ex_rs_data <= rs_data;
        ex_rt_data <= rt_data;
        ex_imm     <= imm_id;
    end

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
    import mips_pkg::*;
(
    input  reg_addr_t rs_id,
    input  reg_addr_t rt_id,
    input  logic      branch_id,
    input  logic      ex_mem_read,
    input  logic      ex_reg_write,
    input  reg_addr_t ex_dest,
    input  reg_addr_t ex_rs,
    input  reg_addr_t ex_rt,
    input  logic      mem_reg_write,
    input  logic      mem_mem_read,
    input  reg_addr_t mem_dest,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    output logic      stall,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b,
    output fwd_sel_e  fwd_c,
    output fwd_sel_e  fwd_d
);

    logic load_use;
    logic branch_ex;     // beq operand still in execute
    logic branch_load;   // beq operand loading in memory
    logic mem_hit_a;
    logic mem_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;

    // ------------------------------
    // stalls
    assign load_use    = ex_mem_read && (ex_rt != '0) && (ex_rt == rs_id || ex_rt == rt_id);
    assign branch_ex   = branch_id && ex_reg_write && (ex_dest != '0)
                         && (ex_dest == rs_id || ex_dest == rt_id);
    assign branch_load = branch_id && mem_mem_read && (mem_dest != '0)
                         && (mem_dest == rs_id || mem_dest == rt_id);
    assign stall       = load_use || branch_ex || branch_load;

    // ------------------------------
    // forward selects, ex/mem first
    assign mem_hit_a = mem_reg_write && (mem_dest != '0) && (mem_dest == ex_rs);
    assign mem_hit_b = mem_reg_write && (mem_dest != '0) && (mem_dest == ex_rt);
    assign wb_hit_a  = wb_en && (wb_addr != '0) && (wb_addr == ex_rs);
    assign wb_hit_b  = wb_en && (wb_addr != '0) && (wb_addr == ex_rt);

    assign fwd_a = mem_hit_a ? FWD_EX_MEM : (wb_hit_a ? FWD_MEM_WB : FWD_NONE);
    assign fwd_b = mem_hit_b ? FWD_EX_MEM : (wb_hit_b ? FWD_MEM_WB : FWD_NONE);

    // decode side, wb handled by register file write-through
    assign fwd_c = (mem_reg_write && mem_dest != '0 && mem_dest == rs_id) ? FWD_EX_MEM : FWD_NONE;
    assign fwd_d = (mem_reg_write && mem_dest != '0 && mem_dest == rt_id) ? FWD_EX_MEM : FWD_NONE;

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ex_reg_write,
    input  logic      ex_mem_read,
    input  logic      ex_mem_write,
    input  logic      ex_mem_to_reg,
    input  logic      ex_reg_dst,
    input  logic      ex_alu_src,
    input  alu_op_e   ex_alu_op,
    input  word_t     ex_rs_data,
    input  word_t     ex_rt_data,
    input  word_t     ex_imm,
    input  reg_addr_t ex_rt,
    input  reg_addr_t ex_rd,
    input  fwd_sel_e  fwd_a,
    input  fwd_sel_e  fwd_b,
    input  word_t     wb_data,
    output reg_addr_t ex_dest,        // to hazard unit
    output logic      mem_reg_write,  // ex/mem
    output logic      mem_mem_read,
    output logic      mem_mem_write,
    output logic      mem_mem_to_reg,
    output word_t     mem_result,
    output word_t     mem_store_data,
    output reg_addr_t mem_dest
);

    word_t op_a;
    word_t store_data;   // forwarded rt, also sw data
    word_t op_b;
    word_t alu_y;

    always_comb begin
        case (fwd_a)
            FWD_EX_MEM: op_a = mem_result;
            FWD_MEM_WB: op_a = wb_data;
            default:    op_a = ex_rs_data;
        endcase
        case (fwd_b)
            FWD_EX_MEM: store_data = mem_result;
            FWD_MEM_WB: store_data = wb_data;
            default:    store_data = ex_rt_data;
        endcase
    end

    assign op_b    = ex_alu_src ? ex_imm : store_data;
    assign ex_dest = ex_reg_dst ? ex_rd : ex_rt;   // rd for r-type

    // ------------------------------
    // alu
    always_comb begin
        case (ex_alu_op)
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            ALU_SLT: alu_y = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;  // signed
            default: alu_y = op_a + op_b;
        endcase
    end

    // ex/mem
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_reg_write  <= 1'b0;
            mem_mem_read   <= 1'b0;
            mem_mem_write  <= 1'b0;
            mem_mem_to_reg <= 1'b0;
        end else begin
            mem_reg_write  <= ex_reg_write;
            mem_mem_read   <= ex_mem_read;
            mem_mem_write  <= ex_mem_write;
            mem_mem_to_reg <= ex_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        mem_result     <= alu_y;
        mem_store_data <= store_data;
        mem_dest       <= ex_dest;
    end

endmodule

// File: memory_writeback_stage.sv
`timescale 1ns/1ps

module memory_writeback_stage
    import mips_pkg::*;
#(
    parameter int DMEM_WORDS = 64
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      mem_reg_write,
    input  logic      mem_mem_read,
    input  logic      mem_mem_write,
    input  logic      mem_mem_to_reg,
    input  word_t     mem_result,      // address or alu value
    input  word_t     mem_store_data,
    input  reg_addr_t mem_dest,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    localparam int ADDR_W = $clog2(DMEM_WORDS);

    word_t             dmem [DMEM_WORDS];
    logic [ADDR_W-1:0] dmem_idx;
    word_t             load_data;

    assign dmem_idx  = mem_result[ADDR_W+1:2];   // word addressed
    assign load_data = dmem[dmem_idx];           // async read

    // ------------------------------
    // data memory
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_mem_write) begin
            dmem[dmem_idx] <= mem_store_data;
        end
    end

    // mem/wb
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= mem_dest;
        wb_data <= mem_mem_to_reg ? load_data : mem_result;   // lw takes memory word
    end

    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_mem_read && mem_mem_write));

endmodule

// File: mips_core.sv
`timescale 1ns/1ps

module mips_core
    import mips_pkg::*;
#(
    parameter word_t RESET_PC   = 32'h0000_0000,
    parameter int    DMEM_WORDS = 64
) (
    input  logic      clk,
    input  logic      reset,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    // ------------------------------
    // stage to stage nets, named after the ports they join
    logic      stall, pc_src, branch_id;
    word_t     pc_target, instr_id, pc_next_id;
    reg_addr_t rs_id, rt_id;
    fwd_sel_e  fwd_a, fwd_b, fwd_c, fwd_d;

    logic      ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg;   // id/ex
    logic      ex_reg_dst, ex_alu_src;
    alu_op_e   ex_alu_op;
    word_t     ex_rs_data, ex_rt_data, ex_imm;
    reg_addr_t ex_rs, ex_rt, ex_rd, ex_dest;

    logic      mem_reg_write, mem_mem_read, mem_mem_write, mem_mem_to_reg;  // ex/mem
    word_t     mem_result, mem_store_data;
    reg_addr_t mem_dest;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (.*);

    decode_stage u_decode (
        .*,
        .ex_mem_result (mem_result)   // beq forward source
    );

    hazard_unit u_hazard (.*);

    execute_stage u_execute (.*);

    memory_writeback_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem_wb (.*);

endmodule

// File: tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core
    import mips_pkg::*;
();

    localparam int IMEM_WORDS  = 64;
    localparam int IMEM_AW     = $clog2(IMEM_WORDS);
    localparam int WAIT_LIMIT  = 50;    // cycles per wait
    localparam int QUIET_LIMIT = 20;    // idle window after the final jump
    localparam int NAME_CHARS  = 32;

    typedef logic [8*NAME_CHARS-1:0] name_t;

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_data;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    word_t     imem [IMEM_WORDS];       // program image
    reg_addr_t exp_reg [$];             // expected write-backs, program order
    word_t     exp_val [$];
    name_t     exp_test [$];
    int        checks;
    int        errors;
    logic      timed_out;

    mips_core #(
        .RESET_PC   (32'h0000_0000),
        .DMEM_WORDS (64)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    // ------------------------------
    // clock and instruction memory
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t fetch_word(input word_t addr);
        if ($isunknown(addr) || addr[31:IMEM_AW+2] != '0) begin
            return '0;                          // outside the image, nop
        end
        return imem[addr[IMEM_AW+1:2]];
    endfunction

    initial begin
        imem_data = '0;
        forever begin
            @(posedge clk);
            #1;
            imem_data = fetch_word(imem_addr);  // pc settles at the edge
        end
    end

    // ------------------------------
    // compare tasks
    task automatic check_word(input string sig, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic check_reg_addr(input string sig, input reg_addr_t got, input reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, sig, got, exp);
        end
    endtask

    task automatic expect_level(input string sig, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, sig, got, exp);
        end
    endtask

    task automatic print_test_line(input name_t name, input int errs);
        $display("test %0s done, %0d errors", name, errs);
    endtask

    // ------------------------------
    // vectors
    task automatic load_vectors();
        int               fd;
        int               code;
        int               n_words;
        int               wb_flag;
        int               reg_num;
        word_t            word;
        word_t            value;
        name_t            name;
        logic [8*160-1:0] line;
        n_words = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[IMEM_AW'(i)] = {OP_J, 26'(i)};  // self-jump parks a runaway pc
        end
        fd = $fopen("mips_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open mips_vectors.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            code = $sscanf(line, "%h %s %d %d %h", word, name, wb_flag, reg_num, value);
            if (code == 5 && n_words < IMEM_WORDS) begin   // comment lines give 0
                imem[IMEM_AW'(n_words)] = word;
                n_words++;
                if (wb_flag != 0) begin
                    exp_reg.push_back(reg_addr_t'(reg_num));
                    exp_val.push_back(value);
                    exp_test.push_back(name);
                end
            end
        end
        $fclose(fd);
        if (exp_reg.size() == 0) begin
            errors++;
            $display("no expected write-backs were found in mips_vectors.txt");
        end
    endtask

    // ------------------------------
    // test phases
    task automatic wait_writeback(output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);                     // outputs stable mid-cycle
            seen = wb_en;
            n++;
        end
    endtask

    task automatic verify_reset();
        int err_before;
        err_before = errors;
        @(negedge clk);
        check_word("imem_addr", imem_addr, 32'h0000_0000);
        expect_level("wb_en", wb_en, 1'b0);
        for (int n = 0; n < 3; n++) begin       // first word still in flight
            @(negedge clk);
            expect_level("wb_en", wb_en, 1'b0);
        end
        print_test_line("reset", errors - err_before);
    endtask

    task automatic follow_writebacks();
        int err_before;
        int k;
        bit seen;
        err_before = errors;
        k          = 0;
        while (k < exp_reg.size() && !timed_out) begin
            wait_writeback(seen);
            if (!seen) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: no write-back within %0d cycles in test %0s",
                         WAIT_LIMIT, exp_test[k]);
            end else begin
                check_reg_addr("wb_addr", wb_addr, exp_reg[k]);
                check_word("wb_data", wb_data, exp_val[k]);
                if (k == exp_reg.size() - 1 || exp_test[k+1] != exp_test[k]) begin
                    print_test_line(exp_test[k], errors - err_before);
                    err_before = errors;
                end
                k++;
            end
        end
    endtask

    task automatic watch_idle_tail();
        int err_before;
        err_before = errors;
        for (int n = 0; n < QUIET_LIMIT; n++) begin   // self-jump, nothing retires
            @(negedge clk);
            if (wb_en) begin
                errors++;
                $display("unexpected write-back to r%0d after the final jump at %0t",
                         wb_addr, $time);
            end
        end
        print_test_line("final_jump", errors - err_before);
    endtask

    task automatic close_run();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // ------------------------------
    // main sequence
    initial begin
        reset     = 1'b1;
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;
        load_vectors();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        verify_reset();
        follow_writebacks();
        if (!timed_out) begin
            watch_idle_tail();
        end
        close_run();
    end

endmodule

// File: mips_vectors.txt
# columns: program word (hex), test name, write-back flag, expected register, expected value (hex)
# words load from address 0 up; flagged rows give the write-back stream in program order
20010005   alu_forward  1   1    00000005
2022fff8   alu_forward  1   2    fffffffd
00221820   alu_forward  1   3    00000002
00622022   alu_forward  1   4    00000005
0041282a   alu_forward  1   5    00000001
00233025   alu_forward  1   6    00000007
00c23824   alu_forward  1   7    00000005
0022402a   alu_forward  1   8    00000000
ac060008   load_store   0   0    00000000
8c090008   load_store   1   9    00000007
01215020   load_store   1   10   0000000c
ac0a000c   load_store   0   0    00000000
8c0b000c   load_store   1   11   0000000c
200c000c   branch       1   12   0000000c
116c0001   branch       0   0    00000000
200d0063   branch       0   0    00000000
200d0001   branch       1   13   00000001
11a00002   branch       0   0    00000000
21ae0001   branch       1   14   00000002
8c0f0008   branch       1   15   00000007
11e60001   branch       0   0    00000000
2010004d   branch       0   0    00000000
20100003   branch       1   16   00000003
0800001a   jump_r0      0   0    00000000
20110037   jump_r0      0   0    00000000
20110042   jump_r0      0   0    00000000
20000009   jump_r0      1   0    00000009
00009020   jump_r0      1   18   00000000
0800001c   jump_r0      0   0    00000000

// File: sim.f
mips_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
memory_writeback_stage.sv
mips_core.sv
tb_mips_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || { echo "simulation did not finish"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
